// File: gpuIsaPkg.sv
package gpuIsaPkg;

	localparam int INSTR_W = 32;
	localparam int REG_W = 5;
	localparam int IMM_W = 16;
	localparam int ADDR_W = 26;
	localparam int DOT_S_POS = 4; // Opcode bit that marks the .S variant

	// Base opcodes, bit 4 already stripped
	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_NOOP = 6'b000001,
		OP_J = 6'b000010,
		OP_CALL = 6'b000011,
		OP_BEQ = 6'b000100,
		OP_RET = 6'b000110,
		OP_BLT = 6'b000111,
		OP_ADDI = 6'b001000,
		OP_ANDI = 6'b001100,
		OP_ORI = 6'b001101,
		OP_XORI = 6'b001110,
		OP_EXIT = 6'b100001,
		OP_LD = 6'b100011,
		OP_LDS = 6'b100111,
		OP_SW = 6'b101011,
		OP_SWS = 6'b101111
	} opcodeE;

	typedef enum logic [5:0] {
		ADD = 6'b100000,
		SUB = 6'b100010,
		MUL = 6'b011000,
		AND = 6'b100100,
		OR = 6'b100101,
		XOR = 6'b100110,
		SHR = 6'b000010,
		SHL = 6'b000000
	} functE;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_MUL = 4'd2,
		ALU_AND = 4'd3,
		ALU_OR = 4'd4,
		ALU_XOR = 4'd5,
		ALU_SHR = 4'd6,
		ALU_SHL = 4'd7,
		ALU_NONE = 4'd15
	} aluOpE;

	function automatic logic [5:0] opField(input logic [INSTR_W-1:0] instr);
		return instr[31:26];
	endfunction

	function automatic opcodeE baseOpcode(input logic [INSTR_W-1:0] instr);
		logic [5:0] op;
		op = opField(instr);
		op[DOT_S_POS] = 1'b0;
		return opcodeE'(op);
	endfunction

	function automatic logic [REG_W-1:0] rsField(input logic [INSTR_W-1:0] instr);
		return instr[25:21];
	endfunction

	function automatic logic [REG_W-1:0] rtField(input logic [INSTR_W-1:0] instr);
		return instr[20:16];
	endfunction

	function automatic logic [REG_W-1:0] rdField(input logic [INSTR_W-1:0] instr);
		return instr[15:11];
	endfunction

	function automatic functE functField(input logic [INSTR_W-1:0] instr);
		return functE'(instr[5:0]);
	endfunction

	function automatic logic [IMM_W-1:0] immField(input logic [INSTR_W-1:0] instr);
		return instr[IMM_W-1:0];
	endfunction

	function automatic logic [ADDR_W-1:0] addrField(input logic [INSTR_W-1:0] instr);
		return instr[ADDR_W-1:0];
	endfunction

endpackage

// File: gpuWarpPkg.sv
package gpuWarpPkg;

	localparam int DEFAULT_WARPS = 8;

	// Decoded control flags of one lane
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic shared; // Shared memory, global when low
		logic src1Valid;
		logic src2Valid;
		logic immValid;
		logic noop;
		logic exitOp;
		logic call;
		logic ret;
		logic jmp;
		logic beq;
		logic blt;
		logic dotS;
		logic illegal;
	} laneCtrlS;

endpackage

// File: fetchBus.sv
`timescale 1ns/1ps

interface fetchBus #(
	parameter int numWarps = gpuWarpPkg::DEFAULT_WARPS
) ();
	import gpuIsaPkg::*;

	logic [INSTR_W-1:0] instr;
	logic [INSTR_W-1:0] pcPlus4;
	logic [numWarps-1:0] fetchMask; // Warp feeding the instruction buffer
	logic [numWarps-1:0] schedMask; // Warp whose PC may change

	modport latch (
		output instr,
		output pcPlus4,
		output fetchMask,
		output schedMask
	);

	modport decoder (
		input instr,
		input pcPlus4,
		input fetchMask,
		input schedMask
	);

endinterface

// File: decodeBus.sv
`timescale 1ns/1ps

interface decodeBus #(
	parameter int numWarps = gpuWarpPkg::DEFAULT_WARPS
) ();
	import gpuIsaPkg::*;
	import gpuWarpPkg::*;

	logic [INSTR_W-1:0] instr;
	logic [INSTR_W-1:0] pcPlus4;
	logic [numWarps-1:0] fetchMask;
	logic [numWarps-1:0] schedMask;
	logic [REG_W-1:0] src1;
	logic [REG_W-1:0] src2;
	logic [REG_W-1:0] dst;
	logic [IMM_W-1:0] imm;
	aluOpE aluOp;
	laneCtrlS ctrl;
	logic [INSTR_W-1:0] targetAddr;
	logic [numWarps-1:0] pcUpdateMask; // Warps redirected by EXIT, CALL or J

	modport decoder (
		output instr,
		output pcPlus4,
		output fetchMask,
		output schedMask,
		output src1,
		output src2,
		output dst,
		output imm,
		output aluOp,
		output ctrl,
		output targetAddr,
		output pcUpdateMask
	);

	modport issue (
		input instr,
		input pcPlus4,
		input fetchMask,
		input schedMask,
		input src1,
		input src2,
		input dst,
		input imm,
		input aluOp,
		input ctrl,
		input targetAddr,
		input pcUpdateMask
	);

endinterface

// File: fetchLatch.sv
`timescale 1ns/1ps

module fetchLatch #(
	parameter int numWarps = gpuWarpPkg::DEFAULT_WARPS
) (
	input logic clk,
	input logic rst,
	input logic fetchStrobe,
	input logic [gpuIsaPkg::INSTR_W-1:0] instr0,
	input logic [gpuIsaPkg::INSTR_W-1:0] instr1,
	input logic [gpuIsaPkg::INSTR_W-1:0] pcPlus40,
	input logic [gpuIsaPkg::INSTR_W-1:0] pcPlus41,
	input logic [numWarps-1:0] fetchMask0,
	input logic [numWarps-1:0] fetchMask1,
	input logic [numWarps-1:0] schedMask0,
	input logic [numWarps-1:0] schedMask1,
	fetchBus.latch lane0,
	fetchBus.latch lane1,
	output logic latchedStrobe
);

	always_ff @(posedge clk) begin
		if (rst) begin
			latchedStrobe <= 1'b0;
			lane0.fetchMask <= '0;
			lane0.schedMask <= '0;
			lane1.fetchMask <= '0;
			lane1.schedMask <= '0;
		end else begin
			latchedStrobe <= fetchStrobe;
			lane0.fetchMask <= fetchStrobe ? fetchMask0 : '0; // No warp without a strobe
			lane0.schedMask <= fetchStrobe ? schedMask0 : '0;
			lane1.fetchMask <= fetchStrobe ? fetchMask1 : '0;
			lane1.schedMask <= fetchStrobe ? schedMask1 : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (fetchStrobe) begin
			lane0.instr <= instr0;
			lane0.pcPlus4 <= pcPlus40;
			lane1.instr <= instr1;
			lane1.pcPlus4 <= pcPlus41;
		end
	end

endmodule

// File: laneDecoder.sv
`timescale 1ns/1ps

module laneDecoder (
	fetchBus.decoder fetchIn,
	decodeBus.decoder decodeOut
);
	import gpuIsaPkg::*;
	import gpuWarpPkg::*;

	opcodeE baseOp;
	logic dotS;
	laneCtrlS ctrl;
	aluOpE aluOp;
	logic redirect;

	assign baseOp = baseOpcode(fetchIn.instr);
	assign dotS = fetchIn.instr[26 + DOT_S_POS];

	always_comb begin
		ctrl = '0;
		ctrl.dotS = dotS;
		case (baseOp)
			OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.src1Valid = 1'b1;
				ctrl.src2Valid = 1'b1;
			end
			OP_NOOP: ctrl.noop = 1'b1;
			OP_J: ctrl.jmp = 1'b1;
			OP_CALL: ctrl.call = 1'b1;
			OP_RET: ctrl.ret = 1'b1;
			OP_BEQ: begin
				ctrl.beq = 1'b1;
				ctrl.src1Valid = 1'b1;
				ctrl.src2Valid = 1'b1;
			end
			OP_BLT: begin
				ctrl.blt = 1'b1;
				ctrl.src1Valid = 1'b1;
				ctrl.src2Valid = 1'b1;
			end
			OP_ADDI, OP_ANDI, OP_ORI, OP_XORI: begin
				ctrl.regWrite = 1'b1;
				ctrl.src1Valid = 1'b1;
				ctrl.immValid = 1'b1;
			end
			OP_EXIT: begin
				ctrl.exitOp = !dotS; // No .S form of EXIT
				ctrl.illegal = dotS;
			end
			OP_LD, OP_LDS: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.src1Valid = 1'b1;
				ctrl.shared = (baseOp == OP_LDS);
			end
			OP_SW, OP_SWS: begin
				ctrl.memWrite = 1'b1;
				ctrl.src1Valid = 1'b1;
				ctrl.src2Valid = 1'b1;
				ctrl.shared = (baseOp == OP_SWS);
			end
			default: ctrl.illegal = 1'b1;
		endcase
	end

	// Immediate forms take the op from the opcode, R-type from funct
	always_comb begin
		aluOp = ALU_NONE;
		if (ctrl.immValid) begin
			case (baseOp)
				OP_ADDI: aluOp = ALU_ADD;
				OP_ANDI: aluOp = ALU_AND;
				OP_ORI: aluOp = ALU_OR;
				OP_XORI: aluOp = ALU_XOR;
				default: aluOp = ALU_NONE;
			endcase
		end else if (baseOp == OP_RTYPE) begin
			case (functField(fetchIn.instr))
				ADD: aluOp = ALU_ADD;
				SUB: aluOp = ALU_SUB;
				MUL: aluOp = ALU_MUL;
				AND: aluOp = ALU_AND;
				OR: aluOp = ALU_OR;
				XOR: aluOp = ALU_XOR;
				SHR: aluOp = ALU_SHR;
				SHL: aluOp = ALU_SHL;
				default: aluOp = ALU_NONE;
			endcase
		end
	end

	assign redirect = ctrl.exitOp || ctrl.call || ctrl.jmp;

	assign decodeOut.instr = fetchIn.instr;
	assign decodeOut.pcPlus4 = fetchIn.pcPlus4;
	assign decodeOut.fetchMask = fetchIn.fetchMask;
	assign decodeOut.schedMask = fetchIn.schedMask;
	assign decodeOut.src1 = rsField(fetchIn.instr);
	assign decodeOut.src2 = rtField(fetchIn.instr);
	assign decodeOut.dst = (ctrl.memRead || ctrl.immValid) ? rtField(fetchIn.instr)
		: rdField(fetchIn.instr); // Loads and immediates write rt
	assign decodeOut.imm = immField(fetchIn.instr);
	assign decodeOut.aluOp = aluOp;
	assign decodeOut.ctrl = ctrl;
	assign decodeOut.targetAddr = {4'b0, addrField(fetchIn.instr), 2'b0};
	assign decodeOut.pcUpdateMask = redirect ? fetchIn.schedMask : '0;

endmodule

// File: issueLatch.sv
`timescale 1ns/1ps

module issueLatch #(
	parameter int numWarps = gpuWarpPkg::DEFAULT_WARPS
) (
	input logic clk,
	input logic rst,
	input logic latchedStrobe,
	decodeBus.issue dec0,
	decodeBus.issue dec1,
	output logic decodeStrobe,
	output logic [gpuIsaPkg::INSTR_W-1:0] ibInstr0,
	output logic [gpuIsaPkg::INSTR_W-1:0] ibInstr1,
	output logic [numWarps-1:0] ibMask0,
	output logic [numWarps-1:0] ibMask1,
	output logic [gpuIsaPkg::REG_W-1:0] src10,
	output logic [gpuIsaPkg::REG_W-1:0] src11,
	output logic [gpuIsaPkg::REG_W-1:0] src20,
	output logic [gpuIsaPkg::REG_W-1:0] src21,
	output logic [gpuIsaPkg::REG_W-1:0] dst0,
	output logic [gpuIsaPkg::REG_W-1:0] dst1,
	output logic [gpuIsaPkg::IMM_W-1:0] imm0,
	output logic [gpuIsaPkg::IMM_W-1:0] imm1,
	output gpuIsaPkg::aluOpE aluOp0,
	output gpuIsaPkg::aluOpE aluOp1,
	output gpuWarpPkg::laneCtrlS ibCtrl0,
	output gpuWarpPkg::laneCtrlS ibCtrl1,
	output logic [gpuIsaPkg::INSTR_W-1:0] simtPcPlus40,
	output logic [gpuIsaPkg::INSTR_W-1:0] simtPcPlus41,
	output logic [numWarps-1:0] simtMask0,
	output logic [numWarps-1:0] simtMask1,
	output logic [gpuIsaPkg::INSTR_W-1:0] pcTarget0,
	output logic [gpuIsaPkg::INSTR_W-1:0] pcTarget1,
	output logic [numWarps-1:0] pcUpdateMask0,
	output logic [numWarps-1:0] pcUpdateMask1
);

	always_ff @(posedge clk) begin
		if (rst) begin
			decodeStrobe <= 1'b0;
			ibMask0 <= '0;
			ibMask1 <= '0;
			simtMask0 <= '0;
			simtMask1 <= '0;
			pcUpdateMask0 <= '0;
			pcUpdateMask1 <= '0;
		end else begin
			decodeStrobe <= latchedStrobe;
			ibMask0 <= latchedStrobe ? dec0.fetchMask : '0;
			ibMask1 <= latchedStrobe ? dec1.fetchMask : '0;
			simtMask0 <= latchedStrobe ? dec0.schedMask : '0;
			simtMask1 <= latchedStrobe ? dec1.schedMask : '0;
			pcUpdateMask0 <= latchedStrobe ? dec0.pcUpdateMask : '0;
			pcUpdateMask1 <= latchedStrobe ? dec1.pcUpdateMask : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (latchedStrobe) begin // Hold last bundle between strobes
			ibInstr0 <= dec0.instr;
			ibInstr1 <= dec1.instr;
			src10 <= dec0.src1;
			src11 <= dec1.src1;
			src20 <= dec0.src2;
			src21 <= dec1.src2;
			dst0 <= dec0.dst;
			dst1 <= dec1.dst;
			imm0 <= dec0.imm;
			imm1 <= dec1.imm;
			aluOp0 <= dec0.aluOp;
			aluOp1 <= dec1.aluOp;
			ibCtrl0 <= dec0.ctrl;
			ibCtrl1 <= dec1.ctrl;
			simtPcPlus40 <= dec0.pcPlus4;
			simtPcPlus41 <= dec1.pcPlus4;
			pcTarget0 <= dec0.targetAddr;
			pcTarget1 <= dec1.targetAddr;
		end
	end

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage #(
	parameter int numWarps = gpuWarpPkg::DEFAULT_WARPS
) (
	input logic clk,
	input logic rst,
	input logic fetchStrobe,
	input logic [gpuIsaPkg::INSTR_W-1:0] instr0,
	input logic [gpuIsaPkg::INSTR_W-1:0] instr1,
	input logic [gpuIsaPkg::INSTR_W-1:0] pcPlus40,
	input logic [gpuIsaPkg::INSTR_W-1:0] pcPlus41,
	input logic [numWarps-1:0] fetchMask0,
	input logic [numWarps-1:0] fetchMask1,
	input logic [numWarps-1:0] schedMask0,
	input logic [numWarps-1:0] schedMask1,
	output logic decodeStrobe,
	output logic [gpuIsaPkg::INSTR_W-1:0] ibInstr0,
	output logic [gpuIsaPkg::INSTR_W-1:0] ibInstr1,
	output logic [numWarps-1:0] ibMask0,
	output logic [numWarps-1:0] ibMask1,
	output logic [gpuIsaPkg::REG_W-1:0] src10,
	output logic [gpuIsaPkg::REG_W-1:0] src11,
	output logic [gpuIsaPkg::REG_W-1:0] src20,
	output logic [gpuIsaPkg::REG_W-1:0] src21,
	output logic [gpuIsaPkg::REG_W-1:0] dst0,
	output logic [gpuIsaPkg::REG_W-1:0] dst1,
	output logic [gpuIsaPkg::IMM_W-1:0] imm0,
	output logic [gpuIsaPkg::IMM_W-1:0] imm1,
	output gpuIsaPkg::aluOpE aluOp0,
	output gpuIsaPkg::aluOpE aluOp1,
	output gpuWarpPkg::laneCtrlS ibCtrl0,
	output gpuWarpPkg::laneCtrlS ibCtrl1,
	output logic [gpuIsaPkg::INSTR_W-1:0] simtPcPlus40,
	output logic [gpuIsaPkg::INSTR_W-1:0] simtPcPlus41,
	output logic [numWarps-1:0] simtMask0,
	output logic [numWarps-1:0] simtMask1,
	output logic [gpuIsaPkg::INSTR_W-1:0] pcTarget0,
	output logic [gpuIsaPkg::INSTR_W-1:0] pcTarget1,
	output logic [numWarps-1:0] pcUpdateMask0,
	output logic [numWarps-1:0] pcUpdateMask1
);

	logic latchedStrobe; // Fetch bundle registered, decode in flight

	fetchBus #(.numWarps(numWarps)) lane0Bus ();
	fetchBus #(.numWarps(numWarps)) lane1Bus ();
	decodeBus #(.numWarps(numWarps)) dec0Bus ();
	decodeBus #(.numWarps(numWarps)) dec1Bus ();

	fetchLatch #(.numWarps(numWarps)) u_fetchLatch (
		.lane0(lane0Bus.latch),
		.lane1(lane1Bus.latch),
		.*
	);

	laneDecoder u_dec0 (
		.fetchIn(lane0Bus.decoder),
		.decodeOut(dec0Bus.decoder)
	);

	laneDecoder u_dec1 (
		.fetchIn(lane1Bus.decoder),
		.decodeOut(dec1Bus.decoder)
	);

	issueLatch #(.numWarps(numWarps)) u_issueLatch (
		.dec0(dec0Bus.issue),
		.dec1(dec1Bus.issue),
		.*
	);

endmodule

// File: decodeStage_sva.sv
`timescale 1ns/1ps

module decodeStageSva #(
	parameter int numWarps = gpuWarpPkg::DEFAULT_WARPS
) (
	input logic clk,
	input logic rst,
	input logic fetchStrobe,
	input logic decodeStrobe,
	input logic [numWarps-1:0] ibMask0,
	input logic [numWarps-1:0] ibMask1,
	input logic [numWarps-1:0] simtMask0,
	input logic [numWarps-1:0] simtMask1,
	input logic [numWarps-1:0] pcUpdateMask0,
	input logic [numWarps-1:0] pcUpdateMask1
);

	logic [6*numWarps-1:0] allMasks;

	assign allMasks = {ibMask0, ibMask1, simtMask0, simtMask1, pcUpdateMask0, pcUpdateMask1};

	strobeLatency: assert property (@(posedge clk) disable iff (rst)
		fetchStrobe |-> ##2 decodeStrobe)
		else $error("decodeStrobe missing two cycles after fetchStrobe");

	noSpuriousStrobe: assert property (@(posedge clk) disable iff (rst)
		decodeStrobe |-> $past(fetchStrobe, 2))
		else $error("decodeStrobe without a fetchStrobe two cycles before");

	masksIdle: assert property (@(posedge clk) disable iff (rst)
		!decodeStrobe |-> (allMasks == '0))
		else $error("Mask output nonzero while decodeStrobe is low");

	masksOneHot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(ibMask0) && $onehot0(ibMask1) && $onehot0(simtMask0)
		&& $onehot0(simtMask1) && $onehot0(pcUpdateMask0) && $onehot0(pcUpdateMask1))
		else $error("Mask output with more than one warp set");

endmodule

bind decodeStage decodeStageSva #(.numWarps(numWarps)) u_sva (.*);

// File: tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		#10 rst = 1'b0; // Released at the usual drive point
	end

endmodule

// File: decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb;
	import gpuIsaPkg::*;
	import gpuWarpPkg::*;

	localparam int numWarps = DEFAULT_WARPS;
	localparam int MAX_CYCLES = 200; // About twice what the tests take

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [numWarps-1:0] fMask;
		logic [numWarps-1:0] sMask;
	} laneInS;

	logic clk;
	logic genRst;
	logic testRst;
	logic dutRst;
	logic fetchStrobe;
	logic [31:0] instr0, instr1, pcPlus40, pcPlus41;
	logic [numWarps-1:0] fetchMask0, fetchMask1, schedMask0, schedMask1;
	logic decodeStrobe;
	logic [31:0] ibInstr0, ibInstr1, simtPcPlus40, simtPcPlus41, pcTarget0, pcTarget1;
	logic [numWarps-1:0] ibMask0, ibMask1, simtMask0, simtMask1, pcUpdateMask0, pcUpdateMask1;
	logic [4:0] src10, src11, src20, src21, dst0, dst1;
	logic [15:0] imm0, imm1;
	aluOpE aluOp0, aluOp1;
	laneCtrlS ibCtrl0, ibCtrl1;

	laneInS q0[$];
	laneInS q1[$];
	int sentAt[$]; // Cycle of each strobe still in flight
	laneInS li0, li1;
	int sendCycle;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int failedTests = 0;
	int cycles = 0;
	int seed = 32'h2512_9a3e;

	assign dutRst = genRst || testRst;

	tbClockGen u_clk (.clk(clk), .rst(genRst));

	decodeStage #(.numWarps(numWarps)) DUT (
		.clk(clk), .rst(dutRst), .fetchStrobe(fetchStrobe),
		.instr0(instr0), .instr1(instr1), .pcPlus40(pcPlus40), .pcPlus41(pcPlus41),
		.fetchMask0(fetchMask0), .fetchMask1(fetchMask1),
		.schedMask0(schedMask0), .schedMask1(schedMask1),
		.decodeStrobe(decodeStrobe), .ibInstr0(ibInstr0), .ibInstr1(ibInstr1),
		.ibMask0(ibMask0), .ibMask1(ibMask1), .src10(src10), .src11(src11),
		.src20(src20), .src21(src21), .dst0(dst0), .dst1(dst1), .imm0(imm0), .imm1(imm1),
		.aluOp0(aluOp0), .aluOp1(aluOp1), .ibCtrl0(ibCtrl0), .ibCtrl1(ibCtrl1),
		.simtPcPlus40(simtPcPlus40), .simtPcPlus41(simtPcPlus41),
		.simtMask0(simtMask0), .simtMask1(simtMask1),
		.pcTarget0(pcTarget0), .pcTarget1(pcTarget1),
		.pcUpdateMask0(pcUpdateMask0), .pcUpdateMask1(pcUpdateMask1)
	);

	function automatic logic [31:0] mkR(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd, logic [5:0] funct);
		return {op, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] mkI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] mkJ(logic [5:0] op, logic [25:0] addr);
		return {op, addr};
	endfunction

	function automatic logic [5:0] dotForm(logic [5:0] op);
		return op | 6'h10;
	endfunction

	function automatic logic [numWarps-1:0] oneHot(int idx);
		logic [numWarps-1:0] m;
		m = '0;
		m[idx] = 1'b1;
		return m;
	endfunction

	function automatic laneInS mkLane(logic [31:0] instr, logic [31:0] pc,
		logic [numWarps-1:0] fMask, logic [numWarps-1:0] sMask);
		laneInS l;
		l.instr = instr;
		l.pc = pc;
		l.fMask = fMask;
		l.sMask = sMask;
		return l;
	endfunction

	// Reference decode, straight from the ISA rules
	function automatic laneCtrlS refCtrl(logic [31:0] instr);
		laneCtrlS c;
		logic [5:0] base;
		base = instr[31:26] & 6'b101111;
		c = '0;
		c.dotS = instr[30];
		case (base)
			OP_RTYPE: {c.regWrite, c.src1Valid, c.src2Valid} = 3'b111;
			OP_NOOP: c.noop = 1'b1;
			OP_J: c.jmp = 1'b1;
			OP_CALL: c.call = 1'b1;
			OP_RET: c.ret = 1'b1;
			OP_BEQ: {c.beq, c.src1Valid, c.src2Valid} = 3'b111;
			OP_BLT: {c.blt, c.src1Valid, c.src2Valid} = 3'b111;
			OP_ADDI, OP_ANDI, OP_ORI, OP_XORI: {c.regWrite, c.src1Valid, c.immValid} = 3'b111;
			OP_EXIT: begin
				c.exitOp = !instr[30];
				c.illegal = instr[30];
			end
			OP_LD: {c.regWrite, c.memRead, c.src1Valid} = 3'b111;
			OP_LDS: {c.regWrite, c.memRead, c.src1Valid, c.shared} = 4'b1111;
			OP_SW: {c.memWrite, c.src1Valid, c.src2Valid} = 3'b111;
			OP_SWS: {c.memWrite, c.src1Valid, c.src2Valid, c.shared} = 4'b1111;
			default: c.illegal = 1'b1;
		endcase
		return c;
	endfunction

	function automatic aluOpE refAluOp(logic [31:0] instr);
		logic [5:0] base;
		base = instr[31:26] & 6'b101111;
		case (base)
			OP_ADDI: return ALU_ADD;
			OP_ANDI: return ALU_AND;
			OP_ORI: return ALU_OR;
			OP_XORI: return ALU_XOR;
			OP_RTYPE: begin
				case (instr[5:0])
					6'b100000: return ALU_ADD;
					6'b100010: return ALU_SUB;
					6'b011000: return ALU_MUL;
					6'b100100: return ALU_AND;
					6'b100101: return ALU_OR;
					6'b100110: return ALU_XOR;
					6'b000010: return ALU_SHR;
					6'b000000: return ALU_SHL;
					default: return ALU_NONE;
				endcase
			end
			default: return ALU_NONE;
		endcase
	endfunction

	task automatic checkAluOp(string name, aluOpE got, aluOpE exp);
		checkCount++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %s (%0d) expected %s (%0d)", $time, name,
				got.name(), got, exp.name(), exp);
			errorCount++;
		end
	endtask

	task automatic checkCtrl(string name, laneCtrlS got, laneCtrlS exp);
		checkCount++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkWord(string name, logic [31:0] got, logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkMask(string name, logic [numWarps-1:0] got, logic [numWarps-1:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkReg(string name, logic [4:0] got, logic [4:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkLane(laneInS li, string tag, logic [31:0] gInstr,
		logic [numWarps-1:0] gIbMask, logic [4:0] gSrc1, logic [4:0] gSrc2, logic [4:0] gDst,
		logic [15:0] gImm, aluOpE gAlu, laneCtrlS gCtrl, logic [31:0] gPc,
		logic [numWarps-1:0] gSimt, logic [31:0] gTgt, logic [numWarps-1:0] gPcUpd);
		laneCtrlS c;
		logic [5:0] base;
		logic [4:0] expDst;
		logic [numWarps-1:0] expUpd;
		c = refCtrl(li.instr);
		base = li.instr[31:26] & 6'b101111;
		expDst = (base inside {OP_LD, OP_LDS, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI})
			? li.instr[20:16] : li.instr[15:11]; // Loads and immediates write rt
		expUpd = (c.exitOp || c.call || c.jmp) ? li.sMask : '0;
		checkWord({tag, ".ibInstr"}, gInstr, li.instr);
		checkMask({tag, ".ibMask"}, gIbMask, li.fMask);
		checkReg({tag, ".src1"}, gSrc1, li.instr[25:21]);
		checkReg({tag, ".src2"}, gSrc2, li.instr[20:16]);
		checkReg({tag, ".dst"}, gDst, expDst);
		checkWord({tag, ".imm"}, {16'd0, gImm}, {16'd0, li.instr[15:0]});
		checkAluOp({tag, ".aluOp"}, gAlu, refAluOp(li.instr));
		checkCtrl({tag, ".ibCtrl"}, gCtrl, c);
		checkWord({tag, ".simtPcPlus4"}, gPc, li.pc);
		checkMask({tag, ".simtMask"}, gSimt, li.sMask);
		checkWord({tag, ".pcTarget"}, gTgt, {4'b0, li.instr[25:0], 2'b0});
		checkMask({tag, ".pcUpdateMask"}, gPcUpd, expUpd);
	endtask

	// Outputs checked mid-cycle, well away from both edges
	always @(negedge clk) begin
		if (!dutRst && decodeStrobe) begin
			if (q0.size() == 0) begin
				$display("Error at %0t: decodeStrobe high with no bundle in flight", $time);
				errorCount++;
			end else begin
				li0 = q0.pop_front();
				li1 = q1.pop_front();
				sendCycle = sentAt.pop_front();
				checkWord("decodeStrobe latency", 32'(cycles - sendCycle), 32'd2);
				checkLane(li0, "lane0", ibInstr0, ibMask0, src10, src20, dst0, imm0, aluOp0,
					ibCtrl0, simtPcPlus40, simtMask0, pcTarget0, pcUpdateMask0);
				checkLane(li1, "lane1", ibInstr1, ibMask1, src11, src21, dst1, imm1, aluOp1,
					ibCtrl1, simtPcPlus41, simtMask1, pcTarget1, pcUpdateMask1);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, %0d bundles never came out", cycles, q0.size());
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic sendPair(laneInS a, laneInS b);
		fetchStrobe = 1'b1;
		{instr0, pcPlus40, fetchMask0, schedMask0} = a;
		{instr1, pcPlus41, fetchMask1, schedMask1} = b;
		q0.push_back(a);
		q1.push_back(b);
		sentAt.push_back(cycles);
		@(posedge clk);
		#10 fetchStrobe = 1'b0;
	endtask

	task automatic waitDrain();
		while (q0.size() != 0)
			@(negedge clk);
		@(posedge clk);
		#10;
	endtask

	task automatic finishTest(string name, int errorsBefore);
		testCount++;
		if (errorCount != errorsBefore)
			failedTests++;
		$display("%-18s %s (%0d errors)", name, (errorCount == errorsBefore) ? "ok" : "FAILED",
			errorCount - errorsBefore);
	endtask

	task automatic aluOpsTest();
		logic [5:0] functs[9];
		logic [5:0] immOps[4];
		int e;
		functs = '{ADD, SUB, MUL, AND, OR, XOR, SHR, SHL, 6'b111111}; // Last one unlisted
		immOps = '{OP_ADDI, OP_ANDI, OP_ORI, OP_XORI};
		e = errorCount;
		for (int i = 0; i < 9; i++)
			sendPair(mkLane(mkR(OP_RTYPE, 5'd1, 5'(i + 2), 5'(i + 10), functs[i]), 32'h100,
				oneHot(0), oneHot(1)),
				mkLane(mkR(dotForm(OP_RTYPE), 5'd3, 5'd4, 5'(31 - i), functs[i]), 32'h104,
				oneHot(2), oneHot(3)));
		for (int i = 0; i < 4; i++)
			sendPair(mkLane(mkI(immOps[i], 5'd5, 5'(i + 6), 16'h8001), 32'h200,
				oneHot(i), oneHot(i)),
				mkLane(mkI(dotForm(immOps[i]), 5'd7, 5'(i + 20), 16'h7ffe), 32'h204,
				oneHot(7), oneHot(4)));
		waitDrain();
		finishTest("aluOps", e);
	endtask

	task automatic memOpsTest();
		int e;
		e = errorCount;
		sendPair(mkLane(mkI(OP_LD, 5'd1, 5'd2, 16'h0010), 32'h300, oneHot(1), oneHot(1)),
			mkLane(mkI(OP_LDS, 5'd3, 5'd4, 16'h0020), 32'h304, oneHot(2), oneHot(2)));
		sendPair(mkLane(mkI(OP_SW, 5'd5, 5'd6, 16'hfff0), 32'h308, oneHot(3), oneHot(3)),
			mkLane(mkI(OP_SWS, 5'd7, 5'd8, 16'h0004), 32'h30c, oneHot(4), oneHot(4)));
		waitDrain();
		finishTest("memOps", e);
	endtask

	task automatic controlFlowTest();
		int e;
		e = errorCount;
		sendPair(mkLane(mkJ(OP_J, 26'h3ff_ffff), 32'h400, oneHot(0), oneHot(5)),
			mkLane(mkJ(OP_CALL, 26'h012_3456), 32'h404, oneHot(1), oneHot(6)));
		sendPair(mkLane(mkJ(OP_EXIT, 26'h000_0040), 32'h408, oneHot(2), oneHot(7)),
			mkLane(mkJ(dotForm(OP_J), 26'h2aa_aaaa), 32'h40c, oneHot(3), oneHot(4)));
		sendPair(mkLane(mkI(OP_BEQ, 5'd1, 5'd2, 16'h0008), 32'h410, oneHot(4), oneHot(3)),
			mkLane(mkI(OP_BLT, 5'd3, 5'd4, 16'hfffc), 32'h414, oneHot(5), oneHot(2)));
		sendPair(mkLane(mkJ(OP_RET, 26'h155_5555), 32'h418, oneHot(6), oneHot(1)),
			mkLane(mkJ(dotForm(OP_CALL), 26'h000_0001), 32'h41c, oneHot(7), oneHot(0)));
		waitDrain();
		finishTest("controlFlow", e);
	endtask

	task automatic illegalOpsTest();
		int e;
		e = errorCount;
		sendPair(mkLane(mkJ(6'b000101, 26'h0), 32'h500, oneHot(0), oneHot(0)),
			mkLane(mkJ(6'b011001, 26'h1), 32'h504, oneHot(1), oneHot(1)));
		sendPair(mkLane(mkJ(dotForm(OP_EXIT), 26'h10), 32'h508, oneHot(2), oneHot(2)),
			mkLane(mkJ(OP_NOOP, 26'h0), 32'h50c, oneHot(3), oneHot(3)));
		sendPair(mkLane(mkJ(dotForm(OP_NOOP), 26'h0), 32'h510, '0, '0),
			mkLane(mkJ(OP_J, 26'h80), 32'h514, '0, '0)); // Empty lanes
		waitDrain();
		finishTest("illegalOps", e);
	endtask

	task automatic randomStreamTest();
		int e;
		e = errorCount;
		for (int i = 0; i < 20; i++)
			sendPair(mkLane($random(seed), $random(seed),
				oneHot(int'($unsigned($random(seed)) % numWarps)),
				oneHot(int'($unsigned($random(seed)) % numWarps))),
				mkLane($random(seed), $random(seed),
				oneHot(int'($unsigned($random(seed)) % numWarps)),
				oneHot(int'($unsigned($random(seed)) % numWarps))));
		waitDrain();
		finishTest("randomStream", e);
	endtask

	task automatic midResetTest();
		int e;
		e = errorCount;
		sendPair(mkLane(mkJ(OP_J, 26'h40), 32'h600, oneHot(1), oneHot(2)),
			mkLane(mkJ(OP_CALL, 26'h80), 32'h604, oneHot(3), oneHot(4)));
		sendPair(mkLane(mkJ(OP_EXIT, 26'h0), 32'h608, oneHot(5), oneHot(6)),
			mkLane(mkI(OP_LD, 5'd1, 5'd2, 16'h0), 32'h60c, oneHot(7), oneHot(0)));
		testRst = 1'b1;
		@(posedge clk);
		#10;
		checkWord("decodeStrobe", {31'd0, decodeStrobe}, 32'd0);
		checkMask("ibMask0", ibMask0, '0);
		checkMask("ibMask1", ibMask1, '0);
		checkMask("simtMask0", simtMask0, '0);
		checkMask("simtMask1", simtMask1, '0);
		checkMask("pcUpdateMask0", pcUpdateMask0, '0);
		checkMask("pcUpdateMask1", pcUpdateMask1, '0);
		@(posedge clk);
		#10 testRst = 1'b0;
		q0.delete(); // Bundles in flight are dropped by reset
		q1.delete();
		sentAt.delete();
		sendPair(mkLane(mkJ(OP_CALL, 26'h44), 32'h610, oneHot(2), oneHot(2)),
			mkLane(mkR(OP_RTYPE, 5'd1, 5'd2, 5'd3, ADD), 32'h614, oneHot(4), oneHot(4)));
		waitDrain();
		finishTest("midReset", e);
	endtask

	initial begin
		testRst = 1'b0;
		fetchStrobe = 1'b0;
		{instr0, instr1, pcPlus40, pcPlus41} = '0;
		{fetchMask0, fetchMask1, schedMask0, schedMask1} = '0;
		@(negedge genRst);
		@(posedge clk);
		#10;
		aluOpsTest();
		memOpsTest();
		controlFlowTest();
		illegalOpsTest();
		randomStreamTest();
		midResetTest();
		$display("Tests run %0d, failed %0d, checks %0d, errors %0d", testCount, failedTests,
			checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: tb.f
gpuIsaPkg.sv
gpuWarpPkg.sv
fetchBus.sv
decodeBus.sv
fetchLatch.sv
laneDecoder.sv
issueLatch.sv
decodeStage.sv
decodeStage_sva.sv
tbClockGen.sv
decodeStageTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = decodeStageTb
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
